// File: src/pagPkg.sv
`default_nettype none

package pagPkg;

  localparam int vmaWidth = 18;
  localparam int pageWidth = 9;
  localparam int offsetWidth = 9;
  localparam int frameWidth = 13;
  localparam int paWidth = 22;
  localparam int dirRows = 128;
  localparam int rowWidth = 7;
  localparam int tagWidth = 2;
  localparam int mapDepth = 512;
  localparam int mapAddrWidth = 9;
  localparam int wordWidth = 36;
  localparam int halfWidth = 18;

  // One map halfword without the cache bit
  typedef struct packed {
    logic access;
    logic public;
    logic writable;
    logic software;
    logic [frameWidth-1:0] frame;
  } pageEntry_t;

  typedef struct packed {
    logic user;
    logic write;
    logic paged;
    logic privateTest;
    logic [vmaWidth-1:0] vma;
  } transReq_t;

  typedef enum logic [1:0] {
    pfNone,
    pfNoAccess,
    pfWriteProtect,
    pfProprietary
  } pageFail_e;

  typedef struct packed {
    logic [paWidth-1:0] pa;
    logic ok;
    pageFail_e failCode;
  } transResult_t;

  typedef struct packed {
    logic write;
    logic [mapAddrWidth-1:0] addr;
    logic [wordWidth-1:0] data;
  } memReq_t;

  typedef enum logic [2:0] {
    sIdle,
    sLookup,
    sCheck,
    sFetch,
    sFill
  } ctlState_e;

  // Flags in bits 17..14, bit 13 is the cache bit and is not kept
  function automatic pageEntry_t halfToEntry(input logic [halfWidth-1:0] half);
    pageEntry_t e;
    e.access = half[17];
    e.public = half[16];
    e.writable = half[15];
    e.software = half[14];
    e.frame = half[frameWidth-1:0];
    return e;
  endfunction

endpackage

`default_nettype wire

// File: src/pageTable.sv
`timescale 1ns/1ps
`default_nettype none

module pageTable (
  input  wire logic clk,
  input  wire logic rstN,
  input  wire logic lookupStb,
  input  wire logic [pagPkg::pageWidth-1:0] lookupPage,
  input  wire logic lookupUser,
  input  wire logic fillStb,
  input  wire logic [pagPkg::wordWidth-1:0] fillWord,
  input  wire logic ptClear,
  output logic hit,
  output pagPkg::pageEntry_t entry
);

  // Directory
  logic [pagPkg::dirRows-1:0] validBits;
  logic [pagPkg::tagWidth-1:0] tagMem [pagPkg::dirRows];

  // Even page in the left half, odd page in the right
  pagPkg::pageEntry_t evenMem [pagPkg::dirRows];
  pagPkg::pageEntry_t oddMem [pagPkg::dirRows];

  logic [pagPkg::rowWidth-1:0] rowIdx;
  logic [pagPkg::tagWidth-1:0] reqTag;

  logic rdValid;
  logic [pagPkg::tagWidth-1:0] rdTag;
  logic [pagPkg::tagWidth-1:0] cmpTag;
  logic halfSel;
  pagPkg::pageEntry_t rdEven;
  pagPkg::pageEntry_t rdOdd;

  // Fill uses the same page address as the lookup
  assign rowIdx = lookupPage[pagPkg::rowWidth:1];
  assign reqTag = {lookupUser, lookupPage[pagPkg::pageWidth-1]};

  // A fill in flight survives a clear in the same cycle
  always_ff @(posedge clk) begin
    if (!rstN) begin
      validBits <= '0;
    end else begin
      if (ptClear) begin
        validBits <= '0;
      end
      if (fillStb) begin
        validBits[rowIdx] <= 1'b1;
      end
    end
  end

  // Both halves written at once, as on a refill cycle
  always_ff @(posedge clk) begin
    if (fillStb) begin
      tagMem[rowIdx] <= reqTag;
      evenMem[rowIdx] <= pagPkg::halfToEntry(
        fillWord[pagPkg::wordWidth-1 -: pagPkg::halfWidth]);
      oddMem[rowIdx] <= pagPkg::halfToEntry(fillWord[pagPkg::halfWidth-1:0]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      rdValid <= 1'b0;
    end else if (lookupStb) begin
      rdValid <= validBits[rowIdx];
    end
  end

  always_ff @(posedge clk) begin
    if (lookupStb) begin
      rdTag <= tagMem[rowIdx];
      cmpTag <= reqTag;
      halfSel <= lookupPage[0];
      rdEven <= evenMem[rowIdx];
      rdOdd <= oddMem[rowIdx];
    end
  end

  assign hit = rdValid && (rdTag == cmpTag);
  assign entry = halfSel ? rdOdd : rdEven;

endmodule

`default_nettype wire

// File: src/pageCheck.sv
`timescale 1ns/1ps
`default_nettype none

module pageCheck (
  input  wire pagPkg::transReq_t req,
  input  wire logic hit,
  input  wire pagPkg::pageEntry_t entry,
  output pagPkg::transResult_t result
);

  logic writeOk;
  logic privateOk;

  assign writeOk = entry.writable || !req.write;
  assign privateOk = entry.public || !req.privateTest;

  always_comb begin
    result.pa = '0;
    result.ok = 1'b0;
    result.failCode = pagPkg::pfNone;
    if (!req.paged) begin
      // Unpaged goes straight through
      result.ok = 1'b1;
      result.pa = pagPkg::paWidth'(req.vma);
    end else if (hit) begin
      if (!entry.access) begin
        result.failCode = pagPkg::pfNoAccess;
      end else if (!writeOk) begin
        result.failCode = pagPkg::pfWriteProtect;
      end else if (!privateOk) begin
        result.failCode = pagPkg::pfProprietary;
      end else begin
        result.ok = 1'b1;
        result.pa = {entry.frame, req.vma[pagPkg::offsetWidth-1:0]};
      end
    end
    // a paged miss is not a fail, the controller refills instead
  end

endmodule

`default_nettype wire

// File: src/pageRefill.sv
`timescale 1ns/1ps
`default_nettype none

module pageRefill (
  input  wire logic clk,
  input  wire logic rstN,
  input  wire logic transReqValid,
  input  wire pagPkg::transReq_t transReq,
  output logic lookupStb,
  output logic [pagPkg::pageWidth-1:0] lookupPage,
  output logic lookupUser,
  input  wire logic hit,
  input  wire pagPkg::pageEntry_t entry,
  output logic fillStb,
  output logic [pagPkg::wordWidth-1:0] fillWord,
  input  wire pagPkg::transResult_t checkResult,
  output logic refillReq,
  output pagPkg::memReq_t refillMem,
  input  wire logic refillGnt,
  input  wire logic rdValid,
  input  wire logic [pagPkg::wordWidth-1:0] rdData,
  output pagPkg::transReq_t latchedReq,
  output logic transDone,
  output pagPkg::transResult_t transResult,
  output logic busy
);

  pagPkg::ctlState_e state;
  pagPkg::ctlState_e stateNext;

  logic accept;
  logic miss;
  logic finish;
  logic [pagPkg::mapAddrWidth-1:0] mapAddr;

  assign accept = (state == pagPkg::sIdle) && transReqValid;
  assign miss = latchedReq.paged && !hit;
  assign finish = (state == pagPkg::sCheck) && !miss;

  // User maps in the low half of the map memory, exec maps in the high half
  assign mapAddr = {~latchedReq.user,
                    latchedReq.vma[pagPkg::vmaWidth-1 -: pagPkg::pageWidth-1]};

  always_comb begin
    stateNext = state;
    case (state)
      pagPkg::sIdle:   if (transReqValid) stateNext = pagPkg::sCheck;
      pagPkg::sLookup: stateNext = pagPkg::sCheck;
      pagPkg::sCheck:  stateNext = miss ? pagPkg::sFetch : pagPkg::sIdle;
      pagPkg::sFetch:  if (refillGnt) stateNext = pagPkg::sFill;
      pagPkg::sFill:   if (rdValid) stateNext = pagPkg::sLookup;
      default:         stateNext = pagPkg::sIdle;
    endcase
  end

  // First lookup goes out with the request, the retry from sLookup
  assign lookupStb = (accept && transReq.paged) || (state == pagPkg::sLookup);
  assign lookupPage = (state == pagPkg::sIdle) ?
                      transReq.vma[pagPkg::vmaWidth-1 -: pagPkg::pageWidth] :
                      latchedReq.vma[pagPkg::vmaWidth-1 -: pagPkg::pageWidth];
  assign lookupUser = (state == pagPkg::sIdle) ? transReq.user : latchedReq.user;

  // Map word written into the table as it arrives
  assign fillStb = (state == pagPkg::sFill) && rdValid;
  assign fillWord = rdData;

  assign refillReq = (state == pagPkg::sFetch);
  always_comb begin
    refillMem.write = 1'b0;
    refillMem.addr = mapAddr;
    refillMem.data = '0;
  end

  assign busy = (state != pagPkg::sIdle);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state <= pagPkg::sIdle;
      transDone <= 1'b0;
    end else begin
      state <= stateNext;
      transDone <= finish;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      latchedReq <= transReq;
    end
    if (finish) begin
      transResult <= checkResult;
    end
  end

endmodule

`default_nettype wire

// File: src/memArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
  input  wire logic clk,
  input  wire logic rstN,
  input  wire logic hostWr,
  input  wire logic [pagPkg::mapAddrWidth-1:0] hostAddr,
  input  wire logic [pagPkg::wordWidth-1:0] hostData,
  input  wire logic refillReq,
  input  wire pagPkg::memReq_t refillMem,
  output logic refillGnt,
  output logic rdValid,
  output logic [pagPkg::wordWidth-1:0] rdData,
  output pagPkg::memReq_t memReq,
  input  wire logic [pagPkg::wordWidth-1:0] memRdData
);

  logic rdPending;

  // Host always wins, refill waits
  assign refillGnt = refillReq && !hostWr;

  always_comb begin
    if (hostWr) begin
      memReq.write = 1'b1;
      memReq.addr = hostAddr;
      memReq.data = hostData;
    end else if (refillReq) begin
      memReq = refillMem;
    end else begin
      memReq = '0;
    end
  end

  // Granted refill read returns next cycle
  always_ff @(posedge clk) begin
    if (!rstN) begin
      rdPending <= 1'b0;
    end else begin
      rdPending <= refillGnt && !refillMem.write;
    end
  end

  assign rdValid = rdPending;
  assign rdData = memRdData;

endmodule

`default_nettype wire

// File: src/pageMapMem.sv
`timescale 1ns/1ps
`default_nettype none

module pageMapMem (
  input  wire logic clk,
  input  wire pagPkg::memReq_t memReq,
  output logic [pagPkg::wordWidth-1:0] memRdData
);

  logic [pagPkg::wordWidth-1:0] mem [pagPkg::mapDepth];

  // Read returns the old word on a same-address write
  always_ff @(posedge clk) begin
    if (memReq.write) begin
      mem[memReq.addr] <= memReq.data;
    end
    memRdData <= mem[memReq.addr];
  end

endmodule

`default_nettype wire

// File: src/pagerTop.sv
`timescale 1ns/1ps
`default_nettype none

module pagerTop (
  input  wire logic clk,
  input  wire logic rstN,
  input  wire logic transReqValid,
  input  wire pagPkg::transReq_t transReq,
  input  wire logic hostWr,
  input  wire logic [pagPkg::mapAddrWidth-1:0] hostAddr,
  input  wire logic [pagPkg::wordWidth-1:0] hostData,
  input  wire logic ptClear,
  output logic transDone,
  output pagPkg::transResult_t transResult,
  output logic busy
);

  logic lookupStb;
  logic [pagPkg::pageWidth-1:0] lookupPage;
  logic lookupUser;
  logic hit;
  pagPkg::pageEntry_t entry;
  logic fillStb;
  logic [pagPkg::wordWidth-1:0] fillWord;
  pagPkg::transResult_t checkResult;
  pagPkg::transReq_t latchedReq;
  logic refillReq;
  pagPkg::memReq_t refillMem;
  logic refillGnt;
  logic rdValid;
  logic [pagPkg::wordWidth-1:0] rdData;
  pagPkg::memReq_t memReq;
  logic [pagPkg::wordWidth-1:0] memRdData;

  pageRefill ctl (
    .clk(clk),
    .rstN(rstN),
    .transReqValid(transReqValid),
    .transReq(transReq),
    .lookupStb(lookupStb),
    .lookupPage(lookupPage),
    .lookupUser(lookupUser),
    .hit(hit),
    .entry(entry),
    .fillStb(fillStb),
    .fillWord(fillWord),
    .checkResult(checkResult),
    .refillReq(refillReq),
    .refillMem(refillMem),
    .refillGnt(refillGnt),
    .rdValid(rdValid),
    .rdData(rdData),
    .latchedReq(latchedReq),
    .transDone(transDone),
    .transResult(transResult),
    .busy(busy)
  );

  pageTable pt (
    .clk(clk),
    .rstN(rstN),
    .lookupStb(lookupStb),
    .lookupPage(lookupPage),
    .lookupUser(lookupUser),
    .fillStb(fillStb),
    .fillWord(fillWord),
    .ptClear(ptClear),
    .hit(hit),
    .entry(entry)
  );

  pageCheck chk (
    .req(latchedReq),
    .hit(hit),
    .entry(entry),
    .result(checkResult)
  );

  memArbiter arb (
    .clk(clk),
    .rstN(rstN),
    .hostWr(hostWr),
    .hostAddr(hostAddr),
    .hostData(hostData),
    .refillReq(refillReq),
    .refillMem(refillMem),
    .refillGnt(refillGnt),
    .rdValid(rdValid),
    .rdData(rdData),
    .memReq(memReq),
    .memRdData(memRdData)
  );

  pageMapMem pmm (
    .clk(clk),
    .memReq(memReq),
    .memRdData(memRdData)
  );

endmodule

`default_nettype wire

// File: verif/pagerTb.sv
`timescale 1ns/1ps
`default_nettype none

module pagerTb;

  localparam int numRandom = 40;
  localparam int numRequests = numRandom + 20;
  localparam int loadCycles = 300;
  localparam int watchdogCycles = numRequests * 40 + loadCycles + 500;

  logic clk;
  logic rstN;
  logic transReqValid;
  pagPkg::transReq_t transReq;
  logic hostWr;
  logic [pagPkg::mapAddrWidth-1:0] hostAddr;
  logic [pagPkg::wordWidth-1:0] hostData;
  logic ptClear;
  logic transDone;
  pagPkg::transResult_t transResult;
  logic busy;

  // Copy of everything the host has written
  logic [pagPkg::wordWidth-1:0] mapMirror [pagPkg::mapDepth];
  integer seed;
  int cycle;

  pagerTop uut (
    .clk(clk),
    .rstN(rstN),
    .transReqValid(transReqValid),
    .transReq(transReq),
    .hostWr(hostWr),
    .hostAddr(hostAddr),
    .hostData(hostData),
    .ptClear(ptClear),
    .transDone(transDone),
    .transResult(transResult),
    .busy(busy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (watchdogCycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", watchdogCycles);
    $display("Testbench failed");
    $fatal(1, "watchdog expired");
  end

  function automatic pagPkg::transReq_t makeReq(input logic user, input logic write,
      input logic paged, input logic privateTest, input logic [17:0] vma);
    return {user, write, paged, privateTest, vma};
  endfunction

  // Halfword layout: access, public, writable, software, cache, frame
  function automatic logic [17:0] makeHalf(input logic access, input logic public,
      input logic writable, input logic [12:0] frame);
    return {access, public, writable, 2'b00, frame};
  endfunction

  function automatic pagPkg::transResult_t expectedResult(input pagPkg::transReq_t req);
    pagPkg::transResult_t r;
    logic [8:0] wordAddr;
    logic [35:0] word;
    logic [17:0] half;
    r.pa = '0;
    r.ok = 1'b0;
    r.failCode = pagPkg::pfNone;
    if (!req.paged) begin
      r.ok = 1'b1;
      r.pa = {4'b0000, req.vma};
    end else begin
      wordAddr = {~req.user, req.vma[17:10]};
      word = mapMirror[wordAddr];
      half = req.vma[9] ? word[17:0] : word[35:18];
      if (!half[17]) begin
        r.failCode = pagPkg::pfNoAccess;
      end else if (req.write && !half[15]) begin
        r.failCode = pagPkg::pfWriteProtect;
      end else if (req.privateTest && !half[16]) begin
        r.failCode = pagPkg::pfProprietary;
      end else begin
        r.ok = 1'b1;
        r.pa = {half[12:0], req.vma[8:0]};
      end
    end
    return r;
  endfunction

  task automatic checkResult(input pagPkg::transResult_t expected,
      input pagPkg::transResult_t actual, input pagPkg::transReq_t req);
    if (actual !== expected) begin
      $display("FAIL at %0t ns: vma %h user %b gave pa %h ok %b code %0d, expected %h %b %0d",
               $time, req.vma, req.user, actual.pa, actual.ok, actual.failCode,
               expected.pa, expected.ok, expected.failCode);
      $display("Testbench failed");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic checkTiming(input int expected, input int actual, input pagPkg::transReq_t req);
    if (actual != expected) begin
      $display("FAIL at %0t ns: vma %h done after %0d cycles, expected %0d",
               $time, req.vma, actual, expected);
      $display("Testbench failed");
      $fatal(1, "latency mismatch");
    end
  endtask

  task automatic checkBusy(input logic expected, input logic actual, input pagPkg::transReq_t req);
    if (actual !== expected) begin
      $display("FAIL at %0t ns: vma %h busy %b, expected %b",
               $time, req.vma, actual, expected);
      $display("Testbench failed");
      $fatal(1, "busy mismatch");
    end
  endtask

  task automatic tick();
    @(posedge clk);
    #2;
    cycle++;
  endtask

  task automatic writeMap(input logic [8:0] addr, input logic [35:0] data);
    hostWr = 1'b1;
    hostAddr = addr;
    hostData = data;
    mapMirror[addr] = data;
    tick();
    hostWr = 1'b0;
  endtask

  task automatic clearTable();
    ptClear = 1'b1;
    tick();
    ptClear = 1'b0;
  endtask

  // Noise writes go to words with address bit 7 set, never used by the requests
  task automatic translate(input pagPkg::transReq_t req, input bit noise, input int expLatency);
    int start;
    logic [31:0] r;
    transReqValid = 1'b1;
    transReq = req;
    start = cycle;
    tick();
    transReqValid = 1'b0;
    while (!transDone) begin
      checkBusy(1'b1, busy, req);
      hostWr = 1'b0;
      transReqValid = 1'b0;
      r = $random(seed);
      if (noise && r[0]) begin
        hostWr = 1'b1;
        hostAddr = {r[8], 1'b1, r[6:0]};
        hostData = {r[31:28], $random(seed)};
        mapMirror[hostAddr] = hostData;
      end
      // Requests strobed while busy must be dropped
      if (noise && r[1]) begin
        transReqValid = 1'b1;
        transReq = makeReq(r[2], r[3], 1'b1, r[4], r[22:5]);
      end
      tick();
    end
    hostWr = 1'b0;
    transReqValid = 1'b0;
    checkBusy(1'b0, busy, req);
    checkResult(expectedResult(req), transResult, req);
    if (expLatency > 0) begin
      checkTiming(expLatency, cycle - start, req);
    end
  endtask

  initial begin
    logic [31:0] r;
    seed = 32'hb957b58a;
    cycle = 0;
    rstN = 1'b0;
    transReqValid = 1'b0;
    transReq = '0;
    hostWr = 1'b0;
    hostAddr = '0;
    hostData = '0;
    ptClear = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    rstN = 1'b1;
    if (transDone !== 1'b0 || busy !== 1'b0) begin
      $display("Done or busy was not low after reset");
      $display("Testbench failed");
      $fatal(1, "reset state wrong");
    end

    // Unpaged
    translate(makeReq(1'b0, 1'b0, 1'b0, 1'b0, 18'h2a5a5), 1'b0, 2);
    translate(makeReq(1'b1, 1'b1, 1'b0, 1'b1, 18'h3ffff), 1'b0, 2);
    translate(makeReq(1'b0, 1'b0, 1'b0, 1'b0, 18'h00000), 1'b0, 2);

    // Exec pages 4 and 5, user pages 0x102 and 0x103
    writeMap(9'd258, {makeHalf(1'b1, 1'b1, 1'b1, 13'h0abc), makeHalf(1'b1, 1'b1, 1'b1, 13'h1234)});
    writeMap(9'd129, {makeHalf(1'b1, 1'b0, 1'b1, 13'h1555), makeHalf(1'b1, 1'b1, 1'b1, 13'h0aaa)});
    clearTable();
    translate(makeReq(1'b0, 1'b0, 1'b1, 1'b0, {9'd4, 9'h055}), 1'b0, 6);
    translate(makeReq(1'b0, 1'b1, 1'b1, 1'b0, {9'd5, 9'h1ff}), 1'b0, 2);
    translate(makeReq(1'b0, 1'b0, 1'b1, 1'b1, {9'd4, 9'h100}), 1'b0, 2);
    translate(makeReq(1'b1, 1'b1, 1'b1, 1'b0, {9'h103, 9'h00f}), 1'b0, 6);
    translate(makeReq(1'b1, 1'b1, 1'b1, 1'b0, {9'h102, 9'h0f0}), 1'b0, 2);

    // Fail priority on exec pages 8 and 9
    writeMap(9'd260, {makeHalf(1'b0, 1'b0, 1'b0, 13'h0123), makeHalf(1'b1, 1'b0, 1'b0, 13'h0777)});
    clearTable();
    translate(makeReq(1'b0, 1'b1, 1'b1, 1'b1, {9'd8, 9'h001}), 1'b0, 6);
    translate(makeReq(1'b0, 1'b1, 1'b1, 1'b1, {9'd9, 9'h002}), 1'b0, 2);
    translate(makeReq(1'b0, 1'b0, 1'b1, 1'b1, {9'd9, 9'h003}), 1'b0, 2);
    translate(makeReq(1'b0, 1'b0, 1'b1, 1'b0, {9'd9, 9'h004}), 1'b0, 2);

    // Rewrite pages 4 and 5
    writeMap(9'd258, {makeHalf(1'b1, 1'b1, 1'b1, 13'h1f0f), makeHalf(1'b1, 1'b1, 1'b0, 13'h0246)});
    clearTable();
    translate(makeReq(1'b0, 1'b0, 1'b1, 1'b0, {9'd4, 9'h055}), 1'b0, 6);
    translate(makeReq(1'b0, 1'b1, 1'b1, 1'b0, {9'd5, 9'h1ff}), 1'b0, 2);

    // Random map for all words the random requests can reach
    for (int i = 0; i < 256; i++) begin
      r = $random(seed);
      writeMap({i[7], 1'b0, i[6:0]}, {r[3:0], $random(seed)});
    end
    clearTable();
    for (int i = 0; i < numRandom; i++) begin
      r = $random(seed);
      translate(makeReq(r[0], r[1], r[2] | r[3], r[4], {1'b0, r[21:5]}), 1'b1, 0);
    end

    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: pager.f
src/pagPkg.sv
src/pageTable.sv
src/pageCheck.sv
src/pageRefill.sv
src/memArbiter.sv
src/pageMapMem.sv
src/pagerTop.sv
verif/pagerTb.sv
